//--- chip_cfg.svh
/*
 * Chip shell configuration constants
 * Pad counts, CTN window, SRAM geometry and POR thresholds
 */
`ifndef CHIP_CFG_SVH
`define CHIP_CFG_SVH

// Pads and GPIO
`define CHIP_GPIO_W     32
`define CHIP_MIO_PADS   21

// CTN egress window
`define CTN_BASE_ADDR   32'h4100_0000
`define CTN_SIZE_BYTES  4096
`define CTN_DW          32

// CTN SRAM geometry in words
`define CTN_SRAM_DEPTH  1024
`define CTN_SRAM_AW     10

// Supply pattern breakpoints, in counter ticks
`define POR_LOW1_END    4
`define POR_HIGH1_END   8
`define POR_LOW2_END    12

`endif

//--- pad_pkg.sv
/*
 * Pad-side types: GPIO word, core pad vectors and pad indices
 */
`include "chip_cfg.svh"

package pad_pkg;

  typedef logic [`CHIP_GPIO_W-1:0]   gpio_word_t;
  typedef logic [`CHIP_MIO_PADS-1:0] mio_vec_t;

  // Core-side multiplexed pad positions
  typedef enum logic [4:0] {
    GEN0, GEN1, GEN2, GEN3, GEN4, GEN5, GEN6,
    GEN7, GEN8, GEN9, GEN10, GEN11, GEN12, GEN13,
    // Software straps
    SW_STRAP0, SW_STRAP1, SW_STRAP2,
    // TAP straps
    TAP_STRAP0, TAP_STRAP1,
    UART_RX,
    UART_TX
  } mio_pad_e;

endpackage

//--- ctn_pkg.sv
/*
 * CTN egress types: bus address, data, byte enables, SRAM word index
 */
`include "chip_cfg.svh"

package ctn_pkg;

  typedef logic [31:0]              ctn_addr_t;
  typedef logic [`CTN_DW-1:0]       ctn_data_t;
  typedef logic [`CTN_DW/8-1:0]     ctn_be_t;

  // Word index into the CTN SRAM
  typedef logic [`CTN_SRAM_AW-1:0]  sram_idx_t;

endpackage

//--- chip_por_gen.sv
/*
 * Power-on reset generator
 * Fakes a low-high-low-high supply ramp and derives the CTN reset from it
 */
`include "chip_cfg.svh"

module chip_por_gen (
  input  logic clk_aon,
  input  logic arst_n_i,
  output logic por_n_o,
  output logic rst_ctn_n_o
);

  logic [3:0] cnt_q;
  logic       vcc_supp;
  logic [1:0] ctn_sync_q;

  // Counts up once and stops at all ones
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != 4'hf) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // Supply level seen by the POR detector
  assign vcc_supp = (cnt_q < 4'(`POR_LOW1_END))  ? 1'b0 :
                    (cnt_q < 4'(`POR_HIGH1_END)) ? 1'b1 :
                    (cnt_q < 4'(`POR_LOW2_END))  ? 1'b0 : 1'b1;

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      por_n_o <= 1'b0;
    end else begin
      por_n_o <= vcc_supp;
    end
  end

  // CTN reset asserts with POR, releases two edges after it
  always_ff @(posedge clk_aon or negedge por_n_o) begin
    if (!por_n_o) begin
      ctn_sync_q <= '0;
    end else begin
      ctn_sync_q <= {ctn_sync_q[0], 1'b1};
    end
  end

  assign rst_ctn_n_o = ctn_sync_q[1];

  // Supply ramp is over once the counter has stopped
  a_por_stable: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    (cnt_q == 4'hf) |=> por_n_o);

endmodule

//--- chip_pad_map.sv
/*
 * Pad mapping between the core pad vectors and the GPIO bus and UART pins
 */
module chip_pad_map (
  input  pad_pkg::gpio_word_t gpio_i,
  input  logic                uart_rx_i,
  output pad_pkg::mio_vec_t   mio_in_o,
  input  pad_pkg::mio_vec_t   mio_out_i,
  input  pad_pkg::mio_vec_t   mio_oe_i,
  input  pad_pkg::mio_vec_t   mio_pull_en_i,
  input  pad_pkg::mio_vec_t   mio_pull_sel_i,
  output pad_pkg::gpio_word_t gpio_o,
  output pad_pkg::gpio_word_t gpio_en_o,
  output pad_pkg::gpio_word_t gpio_pull_en_o,
  output pad_pkg::gpio_word_t gpio_pull_sel_o,
  output logic                uart_tx_o,
  output logic                uart_tx_en_o
);

  ////////////////////////////////////////////////////////////
  // Pad to GPIO direction
  ////////////////////////////////////////////////////////////

  // Same placement for data, enable and both pull attributes
  function automatic pad_pkg::gpio_word_t pad_to_gpio(pad_pkg::mio_vec_t pads);
    pad_pkg::gpio_word_t g;
    g = '0;
    g[13:0] = pads[pad_pkg::GEN13:pad_pkg::GEN0];
    g[22]   = pads[pad_pkg::SW_STRAP0];
    g[23]   = pads[pad_pkg::SW_STRAP1];
    g[24]   = pads[pad_pkg::SW_STRAP2];
    g[27]   = pads[pad_pkg::TAP_STRAP0];
    g[30]   = pads[pad_pkg::TAP_STRAP1];
    return g;
  endfunction

  assign gpio_o          = pad_to_gpio(mio_out_i);
  assign gpio_en_o       = pad_to_gpio(mio_oe_i);
  assign gpio_pull_en_o  = pad_to_gpio(mio_pull_en_i);
  assign gpio_pull_sel_o = pad_to_gpio(mio_pull_sel_i);

  // UART TX leaves on its own pin
  assign uart_tx_o    = mio_out_i[pad_pkg::UART_TX];
  assign uart_tx_en_o = mio_oe_i[pad_pkg::UART_TX];

  ////////////////////////////////////////////////////////////
  // GPIO to pad direction
  ////////////////////////////////////////////////////////////

  always_comb begin
    // UART TX input has no pin and reads 0
    mio_in_o = '0;
    mio_in_o[pad_pkg::GEN13:pad_pkg::GEN0] = gpio_i[13:0];
    mio_in_o[pad_pkg::SW_STRAP0]  = gpio_i[22];
    mio_in_o[pad_pkg::SW_STRAP1]  = gpio_i[23];
    mio_in_o[pad_pkg::SW_STRAP2]  = gpio_i[24];
    mio_in_o[pad_pkg::TAP_STRAP0] = gpio_i[27];
    mio_in_o[pad_pkg::TAP_STRAP1] = gpio_i[30];
    mio_in_o[pad_pkg::UART_RX]    = uart_rx_i;
  end

endmodule

//--- ctn_decode.sv
/*
 * CTN egress decoder
 * Steers window hits to the SRAM and answers misses with an error
 */
`include "chip_cfg.svh"

module ctn_decode (
  input  logic              clk_aon,
  input  logic              rst_ctn_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  ctn_pkg::ctn_addr_t addr_i,
  input  ctn_pkg::ctn_data_t wdata_i,
  input  ctn_pkg::ctn_be_t   be_i,
  output logic              sram_req_o,
  output logic              sram_we_o,
  output ctn_pkg::sram_idx_t sram_idx_o,
  output ctn_pkg::ctn_data_t sram_wdata_o,
  output ctn_pkg::ctn_be_t   sram_be_o,
  input  logic              sram_rvalid_i,
  input  ctn_pkg::ctn_data_t sram_rdata_i,
  output logic              rsp_valid_o,
  output logic              rsp_err_o,
  output ctn_pkg::ctn_data_t rsp_rdata_o
);

  localparam ctn_pkg::ctn_addr_t win_mask = ~ctn_pkg::ctn_addr_t'(`CTN_SIZE_BYTES - 1);

  logic       in_win;
  logic [1:0] err_q;

  assign in_win = (addr_i & win_mask) == ctn_pkg::ctn_addr_t'(`CTN_BASE_ADDR);

  // Window hits go straight to the SRAM, word addressed
  assign sram_req_o   = req_i & in_win;
  assign sram_we_o    = we_i;
  assign sram_idx_o   = addr_i[`CTN_SRAM_AW+1:2];
  assign sram_wdata_o = wdata_i;
  assign sram_be_o    = be_i;

  // Misses ride a two-stage pipe to line up with SRAM latency
  always_ff @(posedge clk_aon or negedge rst_ctn_n_i) begin
    if (!rst_ctn_n_i) begin
      err_q <= '0;
    end else begin
      err_q <= {err_q[0], req_i & ~in_win};
    end
  end

  ////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////

  assign rsp_valid_o = sram_rvalid_i | err_q[1];
  assign rsp_err_o   = err_q[1];
  assign rsp_rdata_o = sram_rvalid_i ? sram_rdata_i : '0;

  // In-order pipes, so SRAM and error slots never collide
  a_rsp_onehot: assert property (@(posedge clk_aon) disable iff (!rst_ctn_n_i)
    !(sram_rvalid_i && err_q[1]));

endmodule

//--- ctn_sram.sv
/*
 * CTN single-port SRAM, input and output registered, byte-masked writes
 */
`include "chip_cfg.svh"

module ctn_sram (
  input  logic               clk_aon,
  input  logic               rst_ctn_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  ctn_pkg::sram_idx_t idx_i,
  input  ctn_pkg::ctn_data_t wdata_i,
  input  ctn_pkg::ctn_be_t   be_i,
  output logic               rvalid_o,
  output ctn_pkg::ctn_data_t rdata_o
);

  ctn_pkg::ctn_data_t mem [`CTN_SRAM_DEPTH];

  logic               req_q;
  logic               we_q;
  ctn_pkg::sram_idx_t idx_q;
  ctn_pkg::ctn_data_t wdata_q;
  ctn_pkg::ctn_be_t   be_q;

  // Control flops of both pipeline stages
  always_ff @(posedge clk_aon or negedge rst_ctn_n_i) begin
    if (!rst_ctn_n_i) begin
      req_q    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      req_q    <= req_i;
      rvalid_o <= req_q;
    end
  end

  // Input stage payload
  always_ff @(posedge clk_aon) begin
    we_q    <= we_i;
    idx_q   <= idx_i;
    wdata_q <= wdata_i;
    be_q    <= be_i;
  end

  // Array access and output register, writes read back as zero
  always_ff @(posedge clk_aon) begin
    rdata_o <= (req_q && !we_q) ? mem[idx_q] : '0;
    if (req_q && we_q) begin
      for (int b = 0; b < `CTN_DW / 8; b++) begin
        if (be_q[b]) begin
          mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  a_idx_known: assert property (@(posedge clk_aon) disable iff (!rst_ctn_n_i)
    req_i |-> !$isunknown(idx_i));

endmodule

//--- chip_top.sv
/*
 * Chip-level shell around the root-of-trust core
 * Pad mapping, power-on reset and the CTN egress SRAM
 */
module chip_top (
  input  logic                clk_aon,
  input  logic                arst_n_i,
  input  pad_pkg::gpio_word_t gpio_i,
  input  logic                uart_rx_i,
  output pad_pkg::mio_vec_t   mio_in_o,
  input  pad_pkg::mio_vec_t   mio_out_i,
  input  pad_pkg::mio_vec_t   mio_oe_i,
  input  pad_pkg::mio_vec_t   mio_pull_en_i,
  input  pad_pkg::mio_vec_t   mio_pull_sel_i,
  output pad_pkg::gpio_word_t gpio_o,
  output pad_pkg::gpio_word_t gpio_en_o,
  output pad_pkg::gpio_word_t gpio_pull_en_o,
  output pad_pkg::gpio_word_t gpio_pull_sel_o,
  output logic                uart_tx_o,
  output logic                uart_tx_en_o,
  output logic                por_n_o,
  input  logic                ctn_req_i,
  input  logic                ctn_we_i,
  input  ctn_pkg::ctn_addr_t  ctn_addr_i,
  input  ctn_pkg::ctn_data_t  ctn_wdata_i,
  input  ctn_pkg::ctn_be_t    ctn_be_i,
  output logic                ctn_rsp_valid_o,
  output logic                ctn_rsp_err_o,
  output ctn_pkg::ctn_data_t  ctn_rsp_rdata_o
);

  logic               rst_ctn_n;
  logic               sram_req;
  logic               sram_we;
  ctn_pkg::sram_idx_t sram_idx;
  ctn_pkg::ctn_data_t sram_wdata;
  ctn_pkg::ctn_be_t   sram_be;
  logic               sram_rvalid;
  ctn_pkg::ctn_data_t sram_rdata;

  chip_por_gen u_por_gen (
    .clk_aon     (clk_aon),
    .arst_n_i    (arst_n_i),
    .por_n_o     (por_n_o),
    .rst_ctn_n_o (rst_ctn_n)
  );

  chip_pad_map u_pad_map (
    .gpio_i          (gpio_i),
    .uart_rx_i       (uart_rx_i),
    .mio_in_o        (mio_in_o),
    .mio_out_i       (mio_out_i),
    .mio_oe_i        (mio_oe_i),
    .mio_pull_en_i   (mio_pull_en_i),
    .mio_pull_sel_i  (mio_pull_sel_i),
    .gpio_o          (gpio_o),
    .gpio_en_o       (gpio_en_o),
    .gpio_pull_en_o  (gpio_pull_en_o),
    .gpio_pull_sel_o (gpio_pull_sel_o),
    .uart_tx_o       (uart_tx_o),
    .uart_tx_en_o    (uart_tx_en_o)
  );

  ////////////////////////////////////////////////////////////
  // CTN egress
  ////////////////////////////////////////////////////////////

  ctn_decode u_ctn_decode (
    .clk_aon       (clk_aon),
    .rst_ctn_n_i   (rst_ctn_n),
    .req_i         (ctn_req_i),
    .we_i          (ctn_we_i),
    .addr_i        (ctn_addr_i),
    .wdata_i       (ctn_wdata_i),
    .be_i          (ctn_be_i),
    .sram_req_o    (sram_req),
    .sram_we_o     (sram_we),
    .sram_idx_o    (sram_idx),
    .sram_wdata_o  (sram_wdata),
    .sram_be_o     (sram_be),
    .sram_rvalid_i (sram_rvalid),
    .sram_rdata_i  (sram_rdata),
    .rsp_valid_o   (ctn_rsp_valid_o),
    .rsp_err_o     (ctn_rsp_err_o),
    .rsp_rdata_o   (ctn_rsp_rdata_o)
  );

  ctn_sram u_ctn_sram (
    .clk_aon     (clk_aon),
    .rst_ctn_n_i (rst_ctn_n),
    .req_i       (sram_req),
    .we_i        (sram_we),
    .idx_i       (sram_idx),
    .wdata_i     (sram_wdata),
    .be_i        (sram_be),
    .rvalid_o    (sram_rvalid),
    .rdata_o     (sram_rdata)
  );

endmodule

//--- tb_chip_checker.sv
/*
 * Testbench checker
 * CTN memory model with response queue, POR shape and pad map checks
 */
`include "chip_cfg.svh"

module tb_chip_checker (
  input  logic                clk_aon,
  input  logic                arst_n_i,
  input  pad_pkg::gpio_word_t gpio_i,
  input  logic                uart_rx_i,
  input  pad_pkg::mio_vec_t   mio_out_i,
  input  pad_pkg::mio_vec_t   mio_oe_i,
  input  pad_pkg::mio_vec_t   mio_pull_en_i,
  input  pad_pkg::mio_vec_t   mio_pull_sel_i,
  input  pad_pkg::mio_vec_t   mio_in_obs_i,
  input  pad_pkg::gpio_word_t gpio_obs_i,
  input  pad_pkg::gpio_word_t gpio_en_obs_i,
  input  pad_pkg::gpio_word_t gpio_pull_en_obs_i,
  input  pad_pkg::gpio_word_t gpio_pull_sel_obs_i,
  input  logic                uart_tx_obs_i,
  input  logic                uart_tx_en_obs_i,
  input  logic                por_n_obs_i,
  input  logic                req_i,
  input  logic                we_i,
  input  ctn_pkg::ctn_addr_t  addr_i,
  input  ctn_pkg::ctn_data_t  wdata_i,
  input  ctn_pkg::ctn_be_t    be_i,
  input  logic                rsp_valid_obs_i,
  input  logic                rsp_err_obs_i,
  input  ctn_pkg::ctn_data_t  rsp_rdata_obs_i,
  output logic                ready_o,
  output int                  pending_o,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] win_mask = ~32'(`CTN_SIZE_BYTES - 1);

  logic [31:0] mem_m [`CTN_SRAM_DEPTH];
  logic [3:0]  wr_m  [`CTN_SRAM_DEPTH];
  int unsigned due_q [$];
  logic        err_q [$];
  logic [31:0] data_q [$];
  logic [31:0] mask_q [$];
  int unsigned cyc;
  int unsigned rst_cyc;
  int unsigned por_rises;
  int unsigned por_hi;
  logic        por_prev;

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    for (int i = 0; i < `CTN_SRAM_DEPTH; i++) begin
      wr_m[i] = 4'h0;
    end
  end

  task automatic flag_error(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  ////////////////////////////////////////////////////////////
  // Pad map reference
  ////////////////////////////////////////////////////////////

  // GPIO bit for pads 0 to 18
  function automatic int gpio_bit(int pad);
    if (pad < 14) return pad;
    if (pad < 17) return pad + 8;
    if (pad == 17) return 27;
    return 30;
  endfunction

  task automatic check_pads();
    pad_pkg::gpio_word_t e_out, e_en, e_pen, e_psel;
    pad_pkg::mio_vec_t   e_in;
    int g;
    e_out  = '0;
    e_en   = '0;
    e_pen  = '0;
    e_psel = '0;
    e_in   = '0;
    for (int p = 0; p < 19; p++) begin
      g = gpio_bit(p);
      e_out[g]  = mio_out_i[p];
      e_en[g]   = mio_oe_i[p];
      e_pen[g]  = mio_pull_en_i[p];
      e_psel[g] = mio_pull_sel_i[p];
      e_in[p]   = gpio_i[g];
    end
    e_in[19] = uart_rx_i;
    chk_cnt_o++;
    if ({gpio_obs_i, gpio_en_obs_i, gpio_pull_en_obs_i, gpio_pull_sel_obs_i} !==
        {e_out, e_en, e_pen, e_psel}) begin
      flag_error($sformatf("GPIO out %h/%h/%h/%h, expected %h/%h/%h/%h", gpio_obs_i,
        gpio_en_obs_i, gpio_pull_en_obs_i, gpio_pull_sel_obs_i, e_out, e_en, e_pen, e_psel));
    end
    if (mio_in_obs_i !== e_in) begin
      flag_error($sformatf("pad inputs %h, expected %h", mio_in_obs_i, e_in));
    end
    if ({uart_tx_obs_i, uart_tx_en_obs_i} !== {mio_out_i[20], mio_oe_i[20]}) begin
      flag_error($sformatf("UART TX %b en %b, expected %b en %b", uart_tx_obs_i,
        uart_tx_en_obs_i, mio_out_i[20], mio_oe_i[20]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // POR shape and CTN reset model
  ////////////////////////////////////////////////////////////

  task automatic track_por();
    if (rst_cyc == 1 && por_n_obs_i !== 1'b0) begin
      flag_error("por_n_o not low after reset");
    end
    if (por_n_obs_i && !por_prev) begin
      por_rises++;
      if (por_rises > 2) flag_error("por_n_o rose a third time");
    end
    if (!por_n_obs_i && por_prev && por_rises >= 2) begin
      flag_error("por_n_o fell after its final rise");
    end
    if (rst_cyc == 32 && !(por_rises == 2 && por_n_obs_i)) begin
      flag_error("POR sequence not finished within 32 cycles");
    end
    por_prev = por_n_obs_i;
    // CTN side leaves reset two edges after the second rise
    ready_o = (por_rises == 2) && (por_hi >= 2);
    por_hi = por_n_obs_i ? por_hi + 1 : 0;
  endtask

  ////////////////////////////////////////////////////////////
  // CTN responses
  ////////////////////////////////////////////////////////////

  task automatic check_response();
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      chk_cnt_o++;
      if (rsp_valid_obs_i !== 1'b1) begin
        flag_error("missing CTN response");
      end else if (rsp_err_obs_i !== err_q[0]) begin
        flag_error($sformatf("CTN err %b, expected %b", rsp_err_obs_i, err_q[0]));
      end else if ((rsp_rdata_obs_i & mask_q[0]) !== (data_q[0] & mask_q[0])) begin
        flag_error($sformatf("CTN rdata %h, expected %h", rsp_rdata_obs_i, data_q[0]));
      end
      void'(due_q.pop_front());
      void'(err_q.pop_front());
      void'(data_q.pop_front());
      void'(mask_q.pop_front());
    end else if (rsp_valid_obs_i !== 1'b0) begin
      flag_error("unexpected CTN response");
    end
  endtask

  task automatic model_request();
    logic [9:0] idx;
    logic [3:0] wr;
    idx = addr_i[11:2];
    wr  = wr_m[idx];
    // Response is seen at the second sample after the request
    due_q.push_back(cyc + 2);
    if ((addr_i & win_mask) != `CTN_BASE_ADDR) begin
      err_q.push_back(1'b1);
      data_q.push_back('0);
      mask_q.push_back('1);
    end else if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem_m[idx][8*b +: 8] = wdata_i[8*b +: 8];
        end
      end
      wr_m[idx] = wr | be_i;
      err_q.push_back(1'b0);
      data_q.push_back('0);
      mask_q.push_back('1);
    end else begin
      // Bytes never written are not compared
      err_q.push_back(1'b0);
      data_q.push_back(mem_m[idx]);
      mask_q.push_back({{8{wr[3]}}, {8{wr[2]}}, {8{wr[1]}}, {8{wr[0]}}});
    end
  endtask

  always @(posedge clk_aon) begin
    if (!arst_n_i) begin
      cyc       = 0;
      rst_cyc   = 0;
      por_rises = 0;
      por_hi    = 0;
      por_prev  = 1'b0;
      ready_o   = 1'b0;
      due_q.delete();
      err_q.delete();
      data_q.delete();
      mask_q.delete();
      pending_o = 0;
    end else begin
      cyc++;
      rst_cyc++;
      check_pads();
      track_por();
      check_response();
      if (ready_o && req_i) begin
        model_request();
      end
      pending_o = due_q.size();
    end
  end

endmodule

//--- tb_chip_top.sv
/*
 * Chip shell testbench top
 * Clock, reset and LFSR stimulus, driven on the falling edge
 */
`include "chip_cfg.svh"

module tb_chip_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit = 200;

  logic                clk_aon;
  logic                arst_n_i;
  pad_pkg::gpio_word_t gpio_in;
  logic                uart_rx;
  pad_pkg::mio_vec_t   mio_out, mio_oe, mio_pull_en, mio_pull_sel, mio_in;
  pad_pkg::gpio_word_t gpio_out, gpio_en, gpio_pull_en, gpio_pull_sel;
  logic                uart_tx, uart_tx_en, por_n;
  logic                ctn_req, ctn_we;
  ctn_pkg::ctn_addr_t  ctn_addr;
  ctn_pkg::ctn_data_t  ctn_wdata, rsp_rdata;
  ctn_pkg::ctn_be_t    ctn_be;
  logic                rsp_valid, rsp_err, ctn_ready;
  int                  pending, err_cnt, chk_cnt, tests_run, err_mark, n;
  logic [31:0]         lfsr_q, a_addr, a_data;
  logic [3:0]          a_be;
  logic                a_we;

  chip_top dut_i (
    .clk_aon (clk_aon), .arst_n_i (arst_n_i),
    .gpio_i (gpio_in), .uart_rx_i (uart_rx), .mio_in_o (mio_in),
    .mio_out_i (mio_out), .mio_oe_i (mio_oe),
    .mio_pull_en_i (mio_pull_en), .mio_pull_sel_i (mio_pull_sel),
    .gpio_o (gpio_out), .gpio_en_o (gpio_en),
    .gpio_pull_en_o (gpio_pull_en), .gpio_pull_sel_o (gpio_pull_sel),
    .uart_tx_o (uart_tx), .uart_tx_en_o (uart_tx_en), .por_n_o (por_n),
    .ctn_req_i (ctn_req), .ctn_we_i (ctn_we), .ctn_addr_i (ctn_addr),
    .ctn_wdata_i (ctn_wdata), .ctn_be_i (ctn_be),
    .ctn_rsp_valid_o (rsp_valid), .ctn_rsp_err_o (rsp_err), .ctn_rsp_rdata_o (rsp_rdata)
  );

  tb_chip_checker chk_i (
    .clk_aon (clk_aon), .arst_n_i (arst_n_i),
    .gpio_i (gpio_in), .uart_rx_i (uart_rx),
    .mio_out_i (mio_out), .mio_oe_i (mio_oe),
    .mio_pull_en_i (mio_pull_en), .mio_pull_sel_i (mio_pull_sel),
    .mio_in_obs_i (mio_in), .gpio_obs_i (gpio_out), .gpio_en_obs_i (gpio_en),
    .gpio_pull_en_obs_i (gpio_pull_en), .gpio_pull_sel_obs_i (gpio_pull_sel),
    .uart_tx_obs_i (uart_tx), .uart_tx_en_obs_i (uart_tx_en), .por_n_obs_i (por_n),
    .req_i (ctn_req), .we_i (ctn_we), .addr_i (ctn_addr), .wdata_i (ctn_wdata),
    .be_i (ctn_be), .rsp_valid_obs_i (rsp_valid), .rsp_err_obs_i (rsp_err),
    .rsp_rdata_obs_i (rsp_rdata), .ready_o (ctn_ready), .pending_o (pending),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  initial begin
    clk_aon = 1'b0;
    forever #4 clk_aon = ~clk_aon;
  end

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int cnt);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < cnt; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Sixteen words at the bottom of the window
  function automatic logic [31:0] pick_hit_addr();
    return `CTN_BASE_ADDR | (take_bits(4) << 2);
  endfunction

  // Same low 12 bits, different 4 KiB page
  function automatic logic [31:0] pick_miss_addr(logic [31:0] hit);
    logic [19:0] upper;
    upper = take_bits(20);
    if (upper == (`CTN_BASE_ADDR >> 12)) upper = ~upper;
    return {upper, hit[11:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_pads();
    gpio_in      = take_bits(32);
    uart_rx      = take_bits(1);
    mio_out      = take_bits(21);
    mio_oe       = take_bits(21);
    mio_pull_en  = take_bits(21);
    mio_pull_sel = take_bits(21);
  endtask

  task automatic step_idle();
    @(negedge clk_aon);
    drive_pads();
    ctn_req = 1'b0;
  endtask

  task automatic step_req(logic we, logic [31:0] addr, logic [31:0] wdata, logic [3:0] be);
    @(negedge clk_aon);
    drive_pads();
    ctn_req   = 1'b1;
    ctn_we    = we;
    ctn_addr  = addr;
    ctn_wdata = wdata;
    ctn_be    = be;
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timeout while waiting for %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic drain_responses(string what);
    int cnt;
    step_idle();
    cnt = 0;
    while (pending != 0 && cnt < wait_limit) begin
      step_idle();
      cnt++;
    end
    if (pending != 0) stop_on_timeout({what, " responses"});
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (err_cnt == err_mark) $display("[TEST] %s: ok", name);
    else $display("[TEST] %s: %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    lfsr_q       = 32'hdfbc;
    arst_n_i     = 1'b0;
    gpio_in      = '0;
    uart_rx      = 1'b0;
    mio_out      = '0;
    mio_oe       = '0;
    mio_pull_en  = '0;
    mio_pull_sel = '0;
    ctn_req      = 1'b0;
    ctn_we       = 1'b0;
    ctn_addr     = '0;
    ctn_wdata    = '0;
    ctn_be       = '0;
    tests_run    = 0;
    err_mark     = 0;
    repeat (3) @(posedge clk_aon);
    @(negedge clk_aon);
    arst_n_i = 1'b1;

    // Reads only while the CTN side is held, memory stays untouched
    n = 0;
    while (!ctn_ready && n < wait_limit) begin
      a_addr = pick_hit_addr();
      if (take_bits(1)) a_addr = pick_miss_addr(a_addr);
      if (take_bits(1)) step_req(1'b0, a_addr, '0, '0);
      else step_idle();
      n++;
    end
    if (!ctn_ready) stop_on_timeout("CTN reset release");
    drain_responses("reset phase");
    end_test("no response in reset");
    repeat (20) step_idle();
    end_test("POR shape");

    for (int i = 0; i < 40; i++) begin
      a_addr = pick_hit_addr();
      a_data = take_bits(32);
      a_be   = take_bits(4);
      step_req(1'b1, a_addr, a_data, a_be);
      step_idle();
    end
    for (int i = 0; i < 40; i++) begin
      step_req(1'b0, pick_hit_addr(), '0, '0);
      step_idle();
    end
    drain_responses("window access");
    end_test("in-window writes and reads");

    for (int i = 0; i < 16; i++) begin
      a_addr = pick_hit_addr();
      a_data = take_bits(32);
      step_req(1'b1, pick_miss_addr(a_addr), a_data, 4'hf);
      step_req(1'b0, pick_miss_addr(a_addr), '0, '0);
      step_req(1'b0, a_addr, '0, '0);
    end
    drain_responses("out-of-window");
    end_test("out-of-window requests");

    for (int i = 0; i < 64; i++) begin
      a_we   = take_bits(1);
      a_addr = pick_hit_addr();
      if (take_bits(2) == 0) a_addr = pick_miss_addr(a_addr);
      a_data = take_bits(32);
      a_be   = take_bits(4);
      step_req(a_we, a_addr, a_data, a_be);
    end
    drain_responses("back-to-back");
    end_test("back-to-back requests");

    repeat (64) step_idle();
    end_test("pad mapping");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
pad_pkg.sv
ctn_pkg.sv
chip_por_gen.sv
chip_pad_map.sv
ctn_decode.sv
ctn_sram.sv
chip_top.sv
tb_chip_checker.sv
tb_chip_top.sv

//--- Bender.yml
package:
  name: chip_shell

sources:
  - include_dirs:
      - .
    files:
      - pad_pkg.sv
      - ctn_pkg.sv
      - chip_por_gen.sv
      - chip_pad_map.sv
      - ctn_decode.sv
      - ctn_sram.sv
      - chip_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_chip_checker.sv
      - tb_chip_top.sv
